// ==== src/wb_pkg.sv ====
// writeback stage definitions
package wb_pkg;

   // widths
   localparam int word_w  = 32;
   localparam int mm_w    = 64;
   localparam int idx_w   = 3;
   localparam int size_w  = 2;
   localparam int fmask_w = 7;
   localparam int ctrl_w  = 19;

   typedef logic [word_w-1:0] word_t;
   typedef logic [word_w-1:0] addr_t;
   typedef logic [mm_w-1:0]   mm_t;
   typedef logic [word_w-1:0] flags_t;
   typedef logic [idx_w-1:0]  reg_idx_t;
   typedef logic [size_w-1:0] size_t;
   typedef logic [ctrl_w-1:0] ctrl_t;

   // control word bit positions
   localparam int ctl_ld_gpr3     = 0;
   localparam int ctl_ld_seg      = 1;
   localparam int ctl_ld_mm       = 2;
   localparam int ctl_ld_eip      = 3;
   localparam int ctl_ld_flags    = 4;
   localparam int ctl_is_jne      = 5;
   localparam int ctl_is_jnbe     = 6;
   localparam int ctl_is_cmovc    = 7;
   localparam int ctl_is_halt     = 8;
   localparam int ctl_cmps_first  = 9;
   localparam int ctl_cmps_second = 10;
   localparam int ctl_mm_op       = 11;
   // flag mask occupies bits 18:12, ordered CF PF AF ZF SF DF OF
   localparam int ctl_fmask_lo    = 12;

   // flag positions inside the flags register
   localparam int flag_cf = 0;
   localparam int flag_pf = 2;
   localparam int flag_af = 4;
   localparam int flag_zf = 6;
   localparam int flag_sf = 7;
   localparam int flag_df = 10;
   localparam int flag_of = 11;

   // mask bit i selects flags bit flag_map[i]
   localparam int flag_map [fmask_w] = '{flag_cf, flag_pf, flag_af, flag_zf,
                                         flag_sf, flag_df, flag_of};

endpackage

// ==== src/wb_ctrl_if.sv ====
// retiring micro-op control bus
`timescale 1ns/1ps

interface wb_ctrl_if;
   import wb_pkg::*;

   logic  valid;
   ctrl_t ctrl;
   logic  repne;

   // execute-stage requests
   logic  ld_gpr1_req;
   logic  ld_gpr2_req;
   logic  dcache_write_req;

   // cache back-pressure, owned by the commit block
   logic  stall;

   modport commit (
      input  valid, ctrl, repne,
      input  ld_gpr1_req, ld_gpr2_req, dcache_write_req,
      output stall
   );

   modport observe (
      input valid, ctrl, repne,
      input ld_gpr1_req, ld_gpr2_req, dcache_write_req,
      input stall
   );

endinterface

// ==== src/operand_select_wb.sv ====
// CMPS operand hold and data select
`timescale 1ns/1ps

module operand_select_wb (
   input  logic           clk,
   input  logic           reset,
   wb_ctrl_if.observe     ctrl,
   input  wb_pkg::word_t  result_a,
   input  wb_pkg::mm_t    result_mm,
   output wb_pkg::word_t  data1,
   output wb_pkg::mm_t    dcache_data
);
   import wb_pkg::*;

   word_t cmps_hold;
   logic  capture;

   // first CMPS operand is kept only when that micro-op commits
   assign capture = ctrl.valid & ~ctrl.stall & ctrl.ctrl[ctl_cmps_first];

   always_ff @(posedge clk) begin
      if (reset) begin
         cmps_hold <= '0;
      end else if (capture) begin
         cmps_hold <= result_a;
      end
   end

   // second CMPS micro-op writes back the held operand
   assign data1 = ctrl.ctrl[ctl_cmps_second] ? cmps_hold : result_a;

   // MMX store or zero-extended integer store
   assign dcache_data = ctrl.ctrl[ctl_mm_op] ? result_mm
                                             : {{(mm_w-word_w){1'b0}}, data1};

   a_cmps_exclusive: assert property (
      @(posedge clk) disable iff (reset)
      ctrl.valid |-> !(ctrl.ctrl[ctl_cmps_first] && ctrl.ctrl[ctl_cmps_second])
   ) else $error("cmps_first and cmps_second set in one micro-op");

endmodule

// ==== src/branch_cond_wb.sv ====
// conditional commit for jumps and cmov
`timescale 1ns/1ps

module branch_cond_wb (
   wb_ctrl_if.observe     ctrl,
   input  wb_pkg::flags_t flags,
   output logic           ld_eip_cond,
   output logic           ld_gpr1_cond
);
   import wb_pkg::*;

   logic cf;
   logic zf;
   logic jne_ok;
   logic jnbe_ok;

   // registered flags, before this micro-op's own update
   assign cf = flags[flag_cf];
   assign zf = flags[flag_zf];

   // an unset condition bit lets the load through
   assign jne_ok  = ~ctrl.ctrl[ctl_is_jne]  | ~zf;
   assign jnbe_ok = ~ctrl.ctrl[ctl_is_jnbe] | (~cf & ~zf);

   assign ld_eip_cond = ctrl.ctrl[ctl_ld_eip] & jne_ok & jnbe_ok;

   // cmovc moves only when carry is set
   assign ld_gpr1_cond = ctrl.ld_gpr1_req & (~ctrl.ctrl[ctl_is_cmovc] | cf);

endmodule

// ==== src/commit_valid_wb.sv ====
// commit enables, stall and hazard dependences
`timescale 1ns/1ps

module commit_valid_wb (
   wb_ctrl_if.commit ctrl,
   input  logic      ld_eip_cond,
   input  logic      ld_gpr1_cond,
   input  logic      write_ready,
   output logic      final_ld_gpr1,
   output logic      final_ld_gpr2,
   output logic      final_ld_gpr3,
   output logic      final_ld_seg,
   output logic      final_ld_mm,
   output logic      final_ld_eip,
   output logic      commit_flags,
   output logic      dep_ld_gpr1,
   output logic      dep_ld_gpr2,
   output logic      dep_ld_gpr3,
   output logic      dep_ld_seg,
   output logic      dep_ld_mm,
   output logic      dep_dcache_write,
   output logic      dcache_write
);
   import wb_pkg::*;

   logic go;

   // pending work, independent of stall
   assign dep_ld_gpr1      = ctrl.valid & ld_gpr1_cond;
   assign dep_ld_gpr2      = ctrl.valid & ctrl.ld_gpr2_req;
   assign dep_ld_gpr3      = ctrl.valid & ctrl.ctrl[ctl_ld_gpr3];
   assign dep_ld_seg       = ctrl.valid & ctrl.ctrl[ctl_ld_seg];
   assign dep_ld_mm        = ctrl.valid & ctrl.ctrl[ctl_ld_mm];
   assign dep_dcache_write = ctrl.valid & ctrl.dcache_write_req;

   // cache holds the write until ready
   assign dcache_write = dep_dcache_write;
   assign ctrl.stall   = dep_dcache_write & ~write_ready;
   assign go           = ~ctrl.stall;

   assign final_ld_gpr1 = dep_ld_gpr1 & go;
   assign final_ld_gpr2 = dep_ld_gpr2 & go;
   assign final_ld_gpr3 = dep_ld_gpr3 & go;
   assign final_ld_seg  = dep_ld_seg & go;
   assign final_ld_mm   = dep_ld_mm & go;
   assign final_ld_eip  = ctrl.valid & ld_eip_cond & go;
   assign commit_flags  = ctrl.valid & ctrl.ctrl[ctl_ld_flags] & go;

endmodule

// ==== src/repne_halt_wb.sv ====
// halt and repne termination
`timescale 1ns/1ps

module repne_halt_wb (
   wb_ctrl_if.observe     ctrl,
   input  wb_pkg::flags_t flags,
   input  wb_pkg::word_t  result_c,
   output logic           halt,
   output logic           repne_terminate
);
   import wb_pkg::*;

   logic count_zero;
   logic repne_step;

   assign halt = ctrl.valid & ctrl.ctrl[ctl_is_halt];

   // result_c is the already decremented count
   assign count_zero = (result_c == '0);

   // second half of a repne cmps
   assign repne_step = ctrl.valid & ctrl.ctrl[ctl_cmps_second] & ctrl.repne;

   // stop on a match or an exhausted count
   assign repne_terminate = repne_step & (flags[flag_zf] | count_zero);

   a_halt_repne_excl: assert final (!(halt && repne_terminate))
      else $error("halt and repne_terminate high together");

endmodule

// ==== src/flags_wb.sv ====
// flags register with masked update
`timescale 1ns/1ps

module flags_wb (
   input  logic           clk,
   input  logic           reset,
   input  logic           commit_flags,
   wb_ctrl_if.observe     ctrl,
   input  wb_pkg::flags_t new_flags,
   output wb_pkg::flags_t flags
);
   import wb_pkg::*;

   logic [fmask_w-1:0] mask;
   flags_t             merged;

   assign mask = ctrl.ctrl[ctl_fmask_lo +: fmask_w];

   // only the named flags take the new value
   always_comb begin
      merged = flags;
      for (int i = 0; i < fmask_w; i++) begin
         if (mask[i]) begin
            merged[flag_map[i]] = new_flags[flag_map[i]];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         flags <= '0;
      end else if (commit_flags) begin
         flags <= merged;
      end
   end

   a_flags_hold_on_stall: assert property (
      @(posedge clk) disable iff (reset)
      ctrl.stall |=> $stable(flags)
   ) else $error("flags changed during a stall");

endmodule

// ==== src/writeback.sv ====
// writeback stage top
`timescale 1ns/1ps

module writeback (
   input  logic               clk,
   input  logic               reset,
   input  logic               valid,
   input  wb_pkg::ctrl_t      ctrl,
   input  wb_pkg::addr_t      neip,
   input  logic               repne,
   input  logic               ex_ld_gpr1,
   input  logic               ex_ld_gpr2,
   input  logic               ex_dcache_write,
   input  wb_pkg::size_t      datasize,
   input  wb_pkg::word_t      result_a,
   input  wb_pkg::word_t      result_b,
   input  wb_pkg::word_t      result_c,
   input  wb_pkg::mm_t        result_mm,
   input  wb_pkg::flags_t     new_flags,
   input  wb_pkg::reg_idx_t   dr1,
   input  wb_pkg::reg_idx_t   dr2,
   input  wb_pkg::reg_idx_t   dr3,
   input  wb_pkg::addr_t      address,
   input  logic               write_ready,
   output wb_pkg::reg_idx_t   final_dr1,
   output wb_pkg::reg_idx_t   final_dr2,
   output wb_pkg::reg_idx_t   final_dr3,
   output wb_pkg::word_t      final_data1,
   output wb_pkg::word_t      final_data2,
   output wb_pkg::word_t      final_data3,
   output logic               final_ld_gpr1,
   output logic               final_ld_gpr2,
   output logic               final_ld_gpr3,
   output wb_pkg::size_t      final_datasize,
   output logic               final_ld_seg,
   output wb_pkg::mm_t        final_mm_data,
   output logic               final_ld_mm,
   output wb_pkg::addr_t      final_eip,
   output logic               final_ld_eip,
   output logic               dcache_write,
   output wb_pkg::mm_t        dcache_data,
   output wb_pkg::addr_t      dcache_addr,
   output logic               dep_ld_gpr1,
   output logic               dep_ld_gpr2,
   output logic               dep_ld_gpr3,
   output logic               dep_ld_seg,
   output logic               dep_ld_mm,
   output logic               dep_dcache_write,
   output logic               halt,
   output logic               repne_terminate,
   output logic               stall,
   output logic               cf_forward,
   output logic               af_forward
);
   import wb_pkg::*;

   wb_ctrl_if wb_bus ();

   word_t  data1;
   flags_t cur_flags;
   logic   ld_eip_cond;
   logic   ld_gpr1_cond;
   logic   commit_flags;

   // micro-op control onto the shared bus
   assign wb_bus.valid            = valid;
   assign wb_bus.ctrl             = ctrl;
   assign wb_bus.repne            = repne;
   assign wb_bus.ld_gpr1_req      = ex_ld_gpr1;
   assign wb_bus.ld_gpr2_req      = ex_ld_gpr2;
   assign wb_bus.dcache_write_req = ex_dcache_write;

   operand_select_wb u_operand_select (
      .clk(clk), .reset(reset), .ctrl(wb_bus.observe),
      .result_a(result_a), .result_mm(result_mm),
      .data1(data1), .dcache_data(dcache_data)
   );

   branch_cond_wb u_branch_cond (
      .ctrl(wb_bus.observe), .flags(cur_flags),
      .ld_eip_cond(ld_eip_cond), .ld_gpr1_cond(ld_gpr1_cond)
   );

   commit_valid_wb u_commit_valid (
      .ctrl(wb_bus.commit), .ld_eip_cond(ld_eip_cond),
      .ld_gpr1_cond(ld_gpr1_cond), .write_ready(write_ready),
      .final_ld_gpr1(final_ld_gpr1), .final_ld_gpr2(final_ld_gpr2),
      .final_ld_gpr3(final_ld_gpr3), .final_ld_seg(final_ld_seg),
      .final_ld_mm(final_ld_mm), .final_ld_eip(final_ld_eip),
      .commit_flags(commit_flags),
      .dep_ld_gpr1(dep_ld_gpr1), .dep_ld_gpr2(dep_ld_gpr2),
      .dep_ld_gpr3(dep_ld_gpr3), .dep_ld_seg(dep_ld_seg),
      .dep_ld_mm(dep_ld_mm), .dep_dcache_write(dep_dcache_write),
      .dcache_write(dcache_write)
   );

   repne_halt_wb u_repne_halt (
      .ctrl(wb_bus.observe), .flags(cur_flags), .result_c(result_c),
      .halt(halt), .repne_terminate(repne_terminate)
   );

   flags_wb u_flags (
      .clk(clk), .reset(reset), .commit_flags(commit_flags),
      .ctrl(wb_bus.observe), .new_flags(new_flags), .flags(cur_flags)
   );

   // register file, segment, mmx and eip ports
   assign final_dr1      = dr1;
   assign final_dr2      = dr2;
   assign final_dr3      = dr3;
   assign final_data1    = data1;
   assign final_data2    = result_b;
   assign final_data3    = result_c;
   assign final_datasize = datasize;
   assign final_mm_data  = result_mm;
   assign final_eip      = neip;
   assign dcache_addr    = address;

   assign stall = wb_bus.stall;

   // forwarded from the registered flags
   assign cf_forward = cur_flags[flag_cf];
   assign af_forward = cur_flags[flag_af];

endmodule

// ==== testbench/writeback_tb.sv ====
// writeback stage testbench
`timescale 1ns/1ps

module writeback_tb;
   import wb_pkg::*;

   localparam int n_uops = 2000;
   // room for about four stall cycles per micro-op
   localparam int max_cycles = n_uops * 5;
   localparam int flag_pos [7] = '{0, 2, 4, 6, 7, 10, 11};

   logic clk, reset, valid, repne, ex_ld_gpr1, ex_ld_gpr2, ex_dcache_write, write_ready;
   ctrl_t ctrl;
   addr_t neip, address, final_eip, dcache_addr;
   size_t datasize, final_datasize;
   word_t result_a, result_b, result_c, final_data1, final_data2, final_data3;
   mm_t result_mm, final_mm_data, dcache_data;
   flags_t new_flags;
   reg_idx_t dr1, dr2, dr3, final_dr1, final_dr2, final_dr3;
   logic final_ld_gpr1, final_ld_gpr2, final_ld_gpr3, final_ld_seg, final_ld_mm, final_ld_eip;
   logic dcache_write, dep_ld_gpr1, dep_ld_gpr2, dep_ld_gpr3, dep_ld_seg, dep_ld_mm;
   logic dep_dcache_write, halt, repne_terminate, stall, cf_forward, af_forward;

   // model state
   flags_t m_flags;
   word_t  m_hold;
   logic   exp_stall;
   int     cycles;

   writeback dut (.*);

   initial clk = 1'b0;
   always #10 clk = ~clk;

   task automatic abort_run();
      $display("Simulation failed");
      $fatal(1, "run stopped");
   endtask

   always @(posedge clk) begin
      cycles++;
      if (cycles >= max_cycles) begin
         $display("timeout: the test did not finish within %0d cycles", max_cycles);
         abort_run();
      end
   end

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("error: %s expected %h actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (exp !== act) begin
         $display("error: %s expected %h actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_mm(input string name, input mm_t exp, input mm_t act);
      if (exp !== act) begin
         $display("error: %s expected %h actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_flags(input string name, input flags_t exp, input flags_t act);
      if (exp !== act) begin
         $display("error: %s expected %h actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
      if (exp !== act) begin
         $display("error: %s expected %h actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_size(input string name, input size_t exp, input size_t act);
      if (exp !== act) begin
         $display("error: %s expected %h actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic drive_uop();
      ctrl_t c;
      c = ctrl_t'($urandom);
      // keep the cmps halves apart, and halt away from repne cmps
      if (c[ctl_cmps_first] && c[ctl_cmps_second]) c[ctl_cmps_first] = 1'b0;
      if (c[ctl_cmps_second]) c[ctl_is_halt] = 1'b0;
      ctrl = c;
      valid = ($urandom % 10) < 8;
      {repne, ex_ld_gpr1, ex_ld_gpr2, ex_dcache_write} = 4'($urandom);
      {dr1, dr2, dr3, datasize} = 11'($urandom);
      neip = $urandom;
      address = $urandom;
      result_a = $urandom;
      result_b = $urandom;
      result_c = (($urandom % 4) == 0) ? '0 : word_t'($urandom);
      result_mm = {$urandom, $urandom};
      new_flags = $urandom;
   endtask

   task automatic check_cycle();
      logic cf, zf, eip_ok, gpr1_ok, go;
      word_t d1;
      cf = m_flags[flag_cf];
      zf = m_flags[flag_zf];
      exp_stall = valid & ex_dcache_write & ~write_ready;
      go = ~exp_stall;
      eip_ok = ctrl[ctl_ld_eip];
      if (ctrl[ctl_is_jne] && zf) eip_ok = 1'b0;
      if (ctrl[ctl_is_jnbe] && (cf || zf)) eip_ok = 1'b0;
      gpr1_ok = ex_ld_gpr1 & (~ctrl[ctl_is_cmovc] | cf);
      d1 = ctrl[ctl_cmps_second] ? m_hold : result_a;
      check_bit("stall", exp_stall, stall);
      check_bit("dcache_write", valid & ex_dcache_write, dcache_write);
      check_bit("final_ld_gpr1", valid & gpr1_ok & go, final_ld_gpr1);
      check_bit("final_ld_gpr2", valid & ex_ld_gpr2 & go, final_ld_gpr2);
      check_bit("final_ld_gpr3", valid & ctrl[ctl_ld_gpr3] & go, final_ld_gpr3);
      check_bit("final_ld_seg", valid & ctrl[ctl_ld_seg] & go, final_ld_seg);
      check_bit("final_ld_mm", valid & ctrl[ctl_ld_mm] & go, final_ld_mm);
      check_bit("final_ld_eip", valid & eip_ok & go, final_ld_eip);
      check_bit("dep_ld_gpr1", valid & gpr1_ok, dep_ld_gpr1);
      check_bit("dep_ld_gpr2", valid & ex_ld_gpr2, dep_ld_gpr2);
      check_bit("dep_ld_gpr3", valid & ctrl[ctl_ld_gpr3], dep_ld_gpr3);
      check_bit("dep_ld_seg", valid & ctrl[ctl_ld_seg], dep_ld_seg);
      check_bit("dep_ld_mm", valid & ctrl[ctl_ld_mm], dep_ld_mm);
      check_bit("dep_dcache_write", valid & ex_dcache_write, dep_dcache_write);
      check_bit("halt", valid & ctrl[ctl_is_halt], halt);
      check_bit("repne_terminate", valid & ctrl[ctl_cmps_second] & repne
                & (zf | (result_c == 0)), repne_terminate);
      check_bit("cf_forward", cf, cf_forward);
      check_bit("af_forward", m_flags[flag_af], af_forward);
      check_idx("final_dr1", dr1, final_dr1);
      check_idx("final_dr2", dr2, final_dr2);
      check_idx("final_dr3", dr3, final_dr3);
      check_size("final_datasize", datasize, final_datasize);
      check_word("final_data1", d1, final_data1);
      check_word("final_data2", result_b, final_data2);
      check_word("final_data3", result_c, final_data3);
      check_word("final_eip", neip, final_eip);
      check_word("dcache_addr", address, dcache_addr);
      check_mm("final_mm_data", result_mm, final_mm_data);
      check_mm("dcache_data", ctrl[ctl_mm_op] ? result_mm : {32'h0, d1}, dcache_data);
      check_flags("flags", m_flags, dut.cur_flags);
   endtask

   task automatic update_model();
      if (valid && !exp_stall) begin
         if (ctrl[ctl_ld_flags]) begin
            for (int i = 0; i < 7; i++) begin
               if (ctrl[ctl_fmask_lo + i]) m_flags[flag_pos[i]] = new_flags[flag_pos[i]];
            end
         end
         if (ctrl[ctl_cmps_first]) m_hold = result_a;
      end
   endtask

   initial begin
      int done;
      int seed_val;
      {reset, valid, repne, ex_ld_gpr1, ex_ld_gpr2, ex_dcache_write, write_ready} = 7'b1000000;
      {ctrl, neip, address, datasize, dr1, dr2, dr3} = '0;
      {result_a, result_b, result_c, result_mm, new_flags} = '0;
      m_flags = '0;
      m_hold = '0;
      exp_stall = 1'b0;
      cycles = 0;
      done = 0;
      seed_val = $urandom(32'h939a54f9);
      repeat (8) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      while (done < n_uops) begin
         // upstream holds its micro-op through a stall
         if (!exp_stall) drive_uop();
         write_ready = ($urandom % 4) != 0;
         #8;
         check_cycle();
         @(posedge clk);
         update_model();
         if (!exp_stall) done++;
         @(negedge clk);
      end
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

// ==== verilog.f ====
src/wb_pkg.sv
src/wb_ctrl_if.sv
src/operand_select_wb.sv
src/branch_cond_wb.sv
src/commit_valid_wb.sv
src/repne_halt_wb.sv
src/flags_wb.sv
src/writeback.sv
testbench/writeback_tb.sv
